// File: filelist.f
+incdir+.
mips_isa_pkg.sv
bus_pkg.sv
avalon_mm_if.sv
mips_alu.sv
mips_regfile.sv
avalon_master.sv
avalon_ram.sv
mips_cpu.sv
mips_system.sv
mips_system_tb.sv

// File: mips_system_tb.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mips_system_tb;

    localparam int          HALT_TIMEOUT = 2000;
    localparam int          RESET_CYCLES = 16;
    localparam logic [15:0] DATA_ADDR    = 16'h00C0;    // Word 48, past every program

    logic           clk;
    logic           reset;
    logic           inst_input;
    logic [7:0]     inst_addr;
    bus_pkg::word_t instruction;
    logic           active;
    bus_pkg::word_t register_v0;

    bus_pkg::word_t prog [$];      // Program image, first word at the reset vector

    mips_system uut (
        .clk         (clk),
        .reset       (reset),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #5 clk = ~clk;

    // ************************************************************************
    // Instruction encoding and checking helpers
    // ************************************************************************

    function automatic bus_pkg::word_t r_type(input logic [5:0] funct, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic bus_pkg::word_t i_type(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check(input string signal, input string label,
                         input bus_pkg::word_t actual, input bus_pkg::word_t expected);
        if (actual !== expected) begin
            $display("error: %s = %h, expected %h (%s)", signal, actual, expected, label);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Preload port writes one word per cycle
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            inst_input  = 1'b1;
            inst_addr   = 8'(`RESET_PC + 4 * i);
            instruction = prog[i];
            @(negedge clk);
        end
        inst_input = 1'b0;
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!active) begin
            @(negedge clk);
            cycles++;
            if (cycles > HALT_TIMEOUT) begin
                $display("Timeout: processor never started after reset");
                $display("Test failed");
                $fatal(1);
            end
        end
        cycles = 0;
        while (active) begin
            @(negedge clk);
            cycles++;
            if (cycles > HALT_TIMEOUT) begin
                $display("Timeout: processor never halted on JR to zero");
                $display("Test failed");
                $fatal(1);
            end
        end
    endtask

    // Reset with preload, run to the halt, then compare $2
    task automatic run_program(input string label, input bus_pkg::word_t expected);
        @(negedge clk);
        reset = 1'b1;
        load_program();
        repeat (RESET_CYCLES - prog.size()) @(negedge clk);
        reset = 1'b0;
        wait_halt();
        check("register_v0", label, register_v0, expected);
    endtask

    // $8 = a and $9 = b through LUI and ORI
    task automatic load_operands(input bus_pkg::word_t a, input bus_pkg::word_t b);
        prog.push_back(i_type(mips_isa_pkg::OP_LUI, 5'd0, 5'd8, a[31:16]));
        prog.push_back(i_type(mips_isa_pkg::OP_ORI, 5'd8, 5'd8, a[15:0]));
        prog.push_back(i_type(mips_isa_pkg::OP_LUI, 5'd0, 5'd9, b[31:16]));
        prog.push_back(i_type(mips_isa_pkg::OP_ORI, 5'd9, 5'd9, b[15:0]));
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************

    task automatic reference_program();
        prog.delete();
        prog.push_back(i_type(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd4, 16'hFFFF));
        prog.push_back(i_type(mips_isa_pkg::OP_ADDIU, 5'd4, 5'd4, 16'h0000));
        prog.push_back(r_type(mips_isa_pkg::F_AND, 5'd3, 5'd4, 5'd2));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("reference program", 32'h0000_0000);   // $3 is still zero
    endtask

    task automatic random_r_type(input logic [5:0] funct, input string label);
        bus_pkg::word_t a;
        bus_pkg::word_t b;
        bus_pkg::word_t expected;
        a = $urandom();
        b = $urandom();
        case (funct)
            mips_isa_pkg::F_ADDU: expected = a + b;     // Wraps at 32 bits
            mips_isa_pkg::F_SUBU: expected = a - b;
            mips_isa_pkg::F_AND:  expected = a & b;
            mips_isa_pkg::F_OR:   expected = a | b;
            default:              expected = a ^ b;
        endcase
        prog.delete();
        load_operands(a, b);
        prog.push_back(r_type(funct, 5'd8, 5'd9, 5'd2));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program(label, expected);
    endtask

    task automatic immediate_forms();
        logic [15:0] imm;
        imm = 16'hFF85;
        prog.delete();
        prog.push_back(i_type(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd2, imm));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("ADDIU sign extension", 32'hFFFF_FF85);    // -123

        // $5 holds all ones, so only the zero-extended bits survive ANDI
        imm = 16'h8F0F;
        prog.delete();
        prog.push_back(i_type(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd5, 16'hFFFF));
        prog.push_back(i_type(mips_isa_pkg::OP_ANDI, 5'd5, 5'd2, imm));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("ANDI zero extension", 32'hFFFF_FFFF & {16'h0000, imm});

        imm = 16'hA5A5;
        prog.delete();
        prog.push_back(i_type(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd5, 16'hFFFF));
        prog.push_back(i_type(mips_isa_pkg::OP_XORI, 5'd5, 5'd2, imm));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("XORI zero extension", 32'hFFFF_FFFF ^ {16'h0000, imm});
    endtask

    task automatic comparisons();
        bus_pkg::word_t neg;
        bus_pkg::word_t pos;
        neg = $urandom() | 32'h8000_0000;
        pos = $urandom() & 32'h7FFF_FFFF;
        prog.delete();
        load_operands(neg, pos);
        prog.push_back(r_type(mips_isa_pkg::F_SLT, 5'd8, 5'd9, 5'd2));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("SLT negative vs positive", 32'd1);     // Negative is the smaller

        prog.delete();
        load_operands(neg, pos);
        prog.push_back(r_type(mips_isa_pkg::F_SLTU, 5'd8, 5'd9, 5'd2));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("SLTU negative vs positive", 32'd0);    // Top bit set reads as larger
    endtask

    task automatic memory_round_trip();
        bus_pkg::word_t data;
        data = $urandom();
        prog.delete();
        load_operands(data, 32'h0000_0000);
        prog.push_back(i_type(mips_isa_pkg::OP_SW, 5'd0, 5'd8, DATA_ADDR));
        prog.push_back(i_type(mips_isa_pkg::OP_LW, 5'd0, 5'd2, DATA_ADDR));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("SW then LW", data);

        // Load into $0 must leave it zero
        data = $urandom() | 32'h0000_0100;
        prog.delete();
        load_operands(data, 32'h0000_0000);
        prog.push_back(i_type(mips_isa_pkg::OP_SW, 5'd0, 5'd8, DATA_ADDR));
        prog.push_back(i_type(mips_isa_pkg::OP_LW, 5'd0, 5'd0, DATA_ADDR));
        prog.push_back(i_type(mips_isa_pkg::OP_ORI, 5'd0, 5'd2, 16'h0042));
        prog.push_back(r_type(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
        run_program("LW into $0 ignored", 32'h0000_0042);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        inst_input  = 1'b0;
        inst_addr   = '0;
        instruction = '0;
        void'($urandom(24288));

        reference_program();
        random_r_type(mips_isa_pkg::F_ADDU, "ADDU random");
        random_r_type(mips_isa_pkg::F_SUBU, "SUBU random");
        random_r_type(mips_isa_pkg::F_AND, "AND random");
        random_r_type(mips_isa_pkg::F_OR, "OR random");
        random_r_type(mips_isa_pkg::F_XOR, "XOR random");
        immediate_forms();
        comparisons();
        memory_round_trip();

        $display("Test passed");
        $finish;
    end

endmodule

// File: mips_system.sv
`timescale 1ns/1ns

module mips_system (
    input  logic           clk,
    input  logic           reset,
    input  logic           inst_input,
    input  logic [7:0]     inst_addr,
    input  bus_pkg::word_t instruction,
    output logic           active,
    output bus_pkg::word_t register_v0
);

    // Memory bus between processor and RAM
    avalon_mm_if bus_if ();

    mips_cpu u_cpu (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus_if.master),
        .active      (active),
        .register_v0 (register_v0)
    );

    // Program RAM with its preload port
    avalon_ram u_ram (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus_if.slave),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction)
    );

endmodule

// File: mips_cpu.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mips_cpu (
    input  logic           clk,
    input  logic           reset,
    avalon_mm_if.master    bus,
    output logic           active,
    output bus_pkg::word_t register_v0
);

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_MEM, S_WRITEBACK, S_HALT
    } state_t;

    state_t                state;
    bus_pkg::addr_t        pc;
    mips_isa_pkg::instr_t  ir;
    bus_pkg::word_t        a_reg;           // rs operand
    bus_pkg::word_t        b_reg;           // rt operand, also store data
    bus_pkg::word_t        alu_out;
    logic                  bus_busy;        // Request handed to the master

    bus_pkg::bus_op_t      bus_op;
    bus_pkg::addr_t        bus_addr;
    bus_pkg::word_t        bus_wdata;
    logic                  bus_done;
    bus_pkg::word_t        bus_rdata;

    mips_isa_pkg::alu_op_t alu_op;
    logic                  use_imm;
    logic                  sign_ext;
    logic                  dest_rd;
    logic                  reg_write;
    logic                  is_load;
    logic                  is_store;
    logic                  is_jr;
    logic                  halting;
    bus_pkg::word_t        imm;
    bus_pkg::word_t        alu_b;
    bus_pkg::word_t        alu_result;
    bus_pkg::word_t        rs_data;
    bus_pkg::word_t        rt_data;
    logic [4:0]            wr_addr;
    bus_pkg::word_t        wr_data;
    logic                  wr_en;

    avalon_master u_master (
        .clk       (clk),
        .reset     (reset),
        .bus_op    (bus_op),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_done  (bus_done),
        .bus_rdata (bus_rdata),
        .bus       (bus)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (ir.rs),
        .rt_addr (ir.rt),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .a      (a_reg),
        .b      (alu_b),
        .result (alu_result)
    );

    // ************************************************************************
    // Instruction decode
    // ************************************************************************

    always_comb begin
        alu_op    = mips_isa_pkg::ALU_ADD;
        use_imm   = 1'b1;
        sign_ext  = 1'b1;
        dest_rd   = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_jr     = 1'b0;
        case (ir.opcode)
            mips_isa_pkg::OP_RTYPE: begin
                use_imm   = 1'b0;
                dest_rd   = 1'b1;
                reg_write = 1'b1;
                case (ir.funct)
                    mips_isa_pkg::F_ADDU: alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUBU: alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND:  alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:   alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::F_XOR:  alu_op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::F_SLT:  alu_op = mips_isa_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLTU: alu_op = mips_isa_pkg::ALU_SLTU;
                    mips_isa_pkg::F_JR: begin
                        is_jr     = 1'b1;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0;  // Unsupported funct is a no-op
                endcase
            end
            mips_isa_pkg::OP_ADDIU: reg_write = 1'b1;
            mips_isa_pkg::OP_SLTI: begin
                alu_op    = mips_isa_pkg::ALU_SLT;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_SLTIU: begin
                alu_op    = mips_isa_pkg::ALU_SLTU;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_ANDI: begin
                alu_op    = mips_isa_pkg::ALU_AND;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_ORI: begin
                alu_op    = mips_isa_pkg::ALU_OR;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_XORI: begin
                alu_op    = mips_isa_pkg::ALU_XOR;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_LUI: begin
                alu_op    = mips_isa_pkg::ALU_LUI;
                sign_ext  = 1'b0;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_LW: begin
                is_load   = 1'b1;
                reg_write = 1'b1;
            end
            mips_isa_pkg::OP_SW: is_store = 1'b1;
            default: ;
        endcase
    end

    assign imm = sign_ext ? {{(`DATA_W-16){ir[15]}}, ir[15:0]}
                          : {{(`DATA_W-16){1'b0}}, ir[15:0]};
    assign alu_b   = use_imm ? imm : b_reg;
    assign halting = is_jr && (a_reg == '0);     // JR $0 ends the program

    // Register writeback
    assign wr_addr = dest_rd ? ir.rd : ir.rt;
    assign wr_data = is_load ? bus_rdata : alu_out;
    assign wr_en   = (state == S_WRITEBACK) && reg_write;

    // ************************************************************************
    // Bus requests
    // ************************************************************************

    always_comb begin
        bus_op = bus_pkg::IDLE;
        if (!bus_busy) begin
            if (state == S_FETCH) begin
                bus_op = bus_pkg::READ;
            end else if (state == S_MEM) begin
                bus_op = is_load ? bus_pkg::READ : bus_pkg::WRITE;
            end
        end
    end

    assign bus_addr  = (state == S_MEM) ? alu_out : pc;
    assign bus_wdata = b_reg;

    // ************************************************************************
    // Control FSM
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_FETCH;
            pc       <= `RESET_PC;
            bus_busy <= 1'b0;
            active   <= 1'b0;
        end else begin
            if (state != S_HALT) active <= 1'b1;
            if (bus_op != bus_pkg::IDLE) bus_busy <= 1'b1;
            else if (bus_done) bus_busy <= 1'b0;
            case (state)
                S_FETCH: if (bus_done) state <= S_DECODE;   // Stall on wait states
                S_DECODE: state <= S_EXECUTE;
                S_EXECUTE: begin
                    if (is_jr) begin
                        pc <= a_reg;
                        if (halting) begin
                            state  <= S_HALT;
                            active <= 1'b0;
                        end else begin
                            state <= S_FETCH;
                        end
                    end else begin
                        pc    <= pc + 32'd4;
                        state <= (is_load || is_store) ? S_MEM : S_WRITEBACK;
                    end
                end
                S_MEM: if (bus_done) state <= is_load ? S_WRITEBACK : S_FETCH;
                S_WRITEBACK: state <= S_FETCH;
                S_HALT: state <= S_HALT;        // Parked until reset
                default: state <= S_FETCH;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && bus_done) begin
            ir <= mips_isa_pkg::instr_t'(bus_rdata);
        end
        if (state == S_DECODE) begin
            a_reg <= rs_data;
            b_reg <= rt_data;
        end
        if (state == S_EXECUTE) begin
            alu_out <= alu_result;      // Also the LW/SW byte address
        end
    end

endmodule

// File: avalon_ram.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module avalon_ram (
    input  logic           clk,
    input  logic           reset,
    avalon_mm_if.slave     bus,
    input  logic           inst_input,
    input  logic [7:0]     inst_addr,
    input  bus_pkg::word_t instruction
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    bus_pkg::word_t   mem [`RAM_WORDS];
    logic             wait_done;    // Set in the wait cycle of a request
    logic             request;
    logic [IDX_W-1:0] bus_idx;
    logic [IDX_W-1:0] load_idx;

    assign request  = bus.read || bus.write;
    assign bus_idx  = bus.address[IDX_W+1:2];  // Byte to word, wraps at depth
    assign load_idx = inst_addr[IDX_W+1:2];

    // One wait state on every access
    assign bus.waitrequest = request && !wait_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_done <= 1'b0;
        end else if (request) begin
            wait_done <= !wait_done;
        end
    end

    // ************************************************************************
    // Storage
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (inst_input) begin
            mem[load_idx] <= instruction;  // Preload wins over the bus
        end else if (bus.write && wait_done) begin
            mem[bus_idx] <= bus.writedata;
        end
        if (bus.read && !wait_done) begin
            bus.readdata <= mem[bus_idx];  // Ready for the completing cycle
        end
    end

endmodule

// File: avalon_master.sv
`timescale 1ns/1ns

module avalon_master (
    input  logic             clk,
    input  logic             reset,
    input  bus_pkg::bus_op_t bus_op,
    input  bus_pkg::addr_t   bus_addr,
    input  bus_pkg::word_t   bus_wdata,
    output logic             bus_done,
    output bus_pkg::word_t   bus_rdata,
    avalon_mm_if.master      bus
);

    logic in_flight;
    logic accept;
    logic finish;

    assign in_flight = bus.read || bus.write;
    assign accept    = !in_flight && (bus_op != bus_pkg::IDLE);
    assign finish    = in_flight && !bus.waitrequest;  // Completing edge

    // Strobes and completion pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
            bus_done  <= 1'b0;
        end else begin
            bus_done <= 1'b0;
            if (finish) begin
                bus.read  <= 1'b0;
                bus.write <= 1'b0;
                bus_done  <= 1'b1;
            end else if (accept) begin
                bus.read  <= (bus_op == bus_pkg::READ);
                bus.write <= (bus_op == bus_pkg::WRITE);
            end
        end
    end

    // Address and data stay put while the slave stalls
    always_ff @(posedge clk) begin
        if (accept) begin
            bus.address   <= bus_addr;
            bus.writedata <= bus_wdata;
        end
        if (finish && bus.read) begin
            bus_rdata <= bus.readdata;  // Held until the next read completes
        end
    end

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ns

module mips_regfile (
    input  logic           clk,
    input  logic           reset,
    input  logic [4:0]     rs_addr,
    input  logic [4:0]     rt_addr,
    input  logic [4:0]     wr_addr,
    input  logic           wr_en,
    input  bus_pkg::word_t wr_data,
    output bus_pkg::word_t rs_data,
    output bus_pkg::word_t rt_data,
    output bus_pkg::word_t v0
);

    bus_pkg::word_t regs [32];

    // $0 is cleared by reset and never written, so it reads as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[2];       // Result register watched by the testbench

endmodule

// File: mips_alu.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mips_alu (
    input  mips_isa_pkg::alu_op_t op,
    input  bus_pkg::word_t        a,
    input  bus_pkg::word_t        b,
    output bus_pkg::word_t        result
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            mips_isa_pkg::ALU_ADD:  result = a + b;     // Wraps modulo 2^32
            mips_isa_pkg::ALU_SUB:  result = a - b;
            mips_isa_pkg::ALU_AND:  result = a & b;
            mips_isa_pkg::ALU_OR:   result = a | b;
            mips_isa_pkg::ALU_XOR:  result = a ^ b;
            mips_isa_pkg::ALU_SLT: begin
                result = {{(`DATA_W-1){1'b0}}, lt_signed};
            end
            mips_isa_pkg::ALU_SLTU: begin
                result = {{(`DATA_W-1){1'b0}}, lt_unsigned};
            end
            mips_isa_pkg::ALU_LUI:  result = b << 16;   // Immediate into upper half
            default:                result = a + b;
        endcase
    end

endmodule

// File: avalon_mm_if.sv
`timescale 1ns/1ns

interface avalon_mm_if;

    bus_pkg::addr_t address;        // Byte address
    logic           read;
    logic           write;
    bus_pkg::word_t writedata;
    bus_pkg::word_t readdata;       // Valid when read is high and waitrequest low
    logic           waitrequest;    // Slave stalls the transfer

    modport master (
        output address,
        output read,
        output write,
        output writedata,
        input  readdata,
        input  waitrequest
    );

    modport slave (
        input  address,
        input  read,
        input  write,
        input  writedata,
        output readdata,
        output waitrequest
    );

endinterface

// File: bus_pkg.sv
`include "cpu_macros.svh"

package bus_pkg;

    // ************************************************************************
    // Memory bus types
    // ************************************************************************

    // Request issued by the processor to its bus master
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b10
    } bus_op_t;

    // Data word carried on the bus
    typedef logic [`DATA_W-1:0] word_t;

    // Byte address, word aligned in practice
    typedef logic [31:0] addr_t;

endpackage

// File: mips_isa_pkg.sv
package mips_isa_pkg;

    // ************************************************************************
    // Instruction encodings of the supported MIPS32 subset
    // ************************************************************************

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,   // SPECIAL, operation selected by funct
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_t;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_t;

    // R-type view of an instruction word, immediate is bits 15:0
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_t;

endpackage

// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ************************************************************************
// Processor and memory sizing
// ************************************************************************

// Machine word width
`define DATA_W 32

// RAM depth in words, byte addresses fit in 8 bits
`define RAM_WORDS 64

// Byte address of the first instruction fetch
`define RESET_PC 32'h0000_0004

`endif
